//--- src.f
src/cachePkg.sv
src/storageCtrlIf.sv
src/cacheStorage.sv
src/cacheControl.sv
src/cacheTop.sv
dv/cacheTop_assertions.sv
dv/cacheTb.sv

//--- run.sh
#!/bin/sh
# build and run the cache testbench, exit status carries the result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert \
    --timescale 1ns/100ps \
    --top-module cacheTb \
    -Mdir obj_dir \
    -o cacheSim \
    -f src.f &&
./obj_dir/cacheSim || exit 1

//--- dv/cacheTb.sv
module cacheTb;
    timeunit 1ns;
    timeprecision 100ps;

    import cachePkg::*;

    localparam int lineCount  = 128;
    localparam int indexWidth = $clog2(lineCount);
    localparam int randomOps  = 300;
    // 300 ops x 2 transfers x ~6 cycles is about 3600 plus margin
    localparam int timeoutCycles = 6000;

    logic isAllocateFinish;  // clock
    logic clk;               // active high reset
    addrT reqAddr;
    wordT reqData;
    logic reqWen;
    logic reqValid;
    wordT resData;
    logic resStall;
    addrT memReqAddr;
    wordT memReqData;
    logic memReqWen;
    logic memReqValid;
    wordT memResData  = '0;
    logic memResValid = 1'b0;

    integer seed = 32'hbaaf_2d2e;

    wordT memArr [addrT];  // words written back to memory
    wordT refArr [addrT];  // last word the pipeline stored

    logic memPending    = 1'b0;  // request seen but not yet answered
    int   delayLeft     = 0;
    int   transferCount = 0;     // completed memory transfers
    addrT lastWbAddr    = '0;    // most recent write-back
    wordT lastWbData    = '0;
    int   cycleCount    = 0;
    int   stallCycles   = 0;     // stalled cycles of the last request

    cacheTop #(
        .lineCount(lineCount)
    ) UUT (
        .isAllocateFinish(isAllocateFinish),
        .clk             (clk),
        .reqAddr         (reqAddr),
        .reqData         (reqData),
        .reqWen          (reqWen),
        .reqValid        (reqValid),
        .resData         (resData),
        .resStall        (resStall),
        .memReqAddr      (memReqAddr),
        .memReqData      (memReqData),
        .memReqWen       (memReqWen),
        .memReqValid     (memReqValid),
        .memResData      (memResData),
        .memResValid     (memResValid)
    );

    initial begin
        isAllocateFinish = 1'b0;
        forever #2 isAllocateFinish = ~isAllocateFinish;  // 4 ns period
    end

    // initial memory word built from every address bit
    function automatic wordT fillPattern(addrT addr);
        return addr ^ {addr[15:0], addr[31:16]} ^ 32'h5a5a_c3c3;
    endfunction

    function automatic wordT memoryWord(addrT addr);
        if (memArr.exists(addr)) begin
            return memArr[addr];
        end
        return fillPattern(addr);
    endfunction

    // last stored word or the initial memory word
    function automatic wordT expectedWord(addrT addr);
        if (refArr.exists(addr)) begin
            return refArr[addr];
        end
        return fillPattern(addr);
    endfunction

    // byte address from tag and line index
    function automatic addrT makeAddr(int tagVal, int indexVal);
        return addrT'((tagVal << (offsetWidth + indexWidth)) | (indexVal << offsetWidth));
    endfunction

    // memory model answers each request after a random wait
    always @(posedge isAllocateFinish) begin
        memResValid <= 1'b0;  // single-cycle pulse
        if (memPending) begin
            if (delayLeft == 0) begin
                memResValid   <= 1'b1;
                memPending    <= 1'b0;
                transferCount <= transferCount + 1;
                if (memReqWen) begin
                    memArr[memReqAddr] = memReqData;
                    lastWbAddr <= memReqAddr;
                    lastWbData <= memReqData;
                end else begin
                    memResData <= memoryWord(memReqAddr);
                end
            end else begin
                delayLeft <= delayLeft - 1;
            end
        end else if (memReqValid && !memResValid) begin
            memPending <= 1'b1;
            delayLeft  <= $random(seed) & 3;  // 0..3 extra cycles
        end
    end

    always @(posedge isAllocateFinish) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutCycles) begin
            $display("timeout: the run did not finish within %0d cycles", timeoutCycles);
            $display("SOME TESTS FAILED");
            $fatal(1, "timeout");
        end
    end

    task automatic failValue(string signalName, wordT expected, wordT actual);
        $display("[FAIL] time=%0t signal=%s expected=%h actual=%h",
                 $time, signalName, expected, actual);
        $display("SOME TESTS FAILED");
        $fatal(1, "mismatch on %s", signalName);
    endtask

    task automatic checkEqual(string signalName, wordT expected, wordT actual);
        assert (actual == expected) else failValue(signalName, expected, actual);
    endtask

    // one pipeline request until resStall is low
    task automatic accessCache(input addrT addr, input logic wen, input wordT data,
                               output wordT rdata);
        @(posedge isAllocateFinish);
        reqAddr  <= addr;
        reqData  <= data;
        reqWen   <= wen;
        reqValid <= 1'b1;
        stallCycles = 0;
        @(negedge isAllocateFinish);
        while (resStall) begin
            stallCycles++;
            @(negedge isAllocateFinish);  // mid-cycle with outputs settled
        end
        rdata = resData;
        if (wen) begin
            refArr[addr] = data;
        end
    endtask

    task automatic writeWord(input addrT addr, input wordT data);
        wordT ignored;
        accessCache(addr, 1'b1, data, ignored);
    endtask

    task automatic checkRead(input addrT addr);
        wordT expected;
        wordT got;
        expected = expectedWord(addr);
        accessCache(addr, 1'b0, '0, got);
        checkEqual("resData", expected, got);
    endtask

    initial begin
        addrT a0;
        addrT a1;
        addrT a2;
        addrT a3;
        addrT randAddr;
        wordT randData;
        int   randVal;
        int   transfersBefore;

        reqAddr  = '0;
        reqData  = '0;
        reqWen   = 1'b0;
        reqValid = 1'b0;
        clk      = 1'b1;
        repeat (5) @(posedge isAllocateFinish);
        clk <= 1'b0;

        a0 = makeAddr(1, 5);
        a1 = makeAddr(2, 5);  // same line as a0
        a2 = makeAddr(3, 9);
        a3 = makeAddr(4, 9);  // same line as a2

        // clean read miss fetches the memory word
        transfersBefore = transferCount;
        checkRead(a0);
        checkEqual("memory transfer count", wordT'(transfersBefore + 1), wordT'(transferCount));

        // write hit then read stay inside the cache
        transfersBefore = transferCount;
        writeWord(a0, 32'hdead_beef);
        checkEqual("resStall cycles", 32'd0, wordT'(stallCycles));  // hit never stalls
        checkRead(a0);
        checkEqual("resStall cycles", 32'd0, wordT'(stallCycles));
        checkEqual("memory transfer count", wordT'(transfersBefore), wordT'(transferCount));

        // conflict on a dirty line sends the victim out first
        transfersBefore = transferCount;
        checkRead(a1);
        checkEqual("memReqAddr", a0, lastWbAddr);
        checkEqual("memReqData", 32'hdead_beef, lastWbData);
        checkEqual("memory transfer count", wordT'(transfersBefore + 2), wordT'(transferCount));
        checkRead(a0);  // now served from memory

        // write miss allocates and merges
        writeWord(a2, 32'h1234_5678);
        transfersBefore = transferCount;
        checkRead(a2);
        checkEqual("memory transfer count", wordT'(transfersBefore), wordT'(transferCount));
        checkRead(a3);  // evicts the merged word
        checkEqual("memReqAddr", a2, lastWbAddr);
        checkEqual("memReqData", 32'h1234_5678, lastWbData);

        // 4 tags on 8 lines keep misses and evictions frequent
        for (int i = 0; i < randomOps; i++) begin
            randAddr = makeAddr($random(seed) & 3, $random(seed) & 7);
            randVal  = $random(seed);
            randData = $random(seed);
            if (randVal[0]) begin
                writeWord(randAddr, randData);
            end else begin
                checkRead(randAddr);
            end
        end

        @(posedge isAllocateFinish);
        reqValid <= 1'b0;
        repeat (4) @(posedge isAllocateFinish);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- dv/cacheTop_assertions.sv
module cacheTopAssertions (
    input logic           isAllocateFinish,  // clock
    input logic           clk,               // async reset active high
    input cachePkg::addrT memReqAddr,
    input cachePkg::wordT memReqData,
    input logic           memReqWen,
    input logic           memReqValid,
    input logic           memResValid
);
    timeunit 1ns;
    timeprecision 100ps;

    // address and direction frozen until memory answers
    property reqHeldUntilResponse;
        @(posedge isAllocateFinish) disable iff (clk)
            memReqValid && !memResValid |=>
                memReqValid && $stable(memReqAddr) && $stable(memReqWen);
    endproperty

    // write payload frozen too
    property writeDataHeld;
        @(posedge isAllocateFinish) disable iff (clk)
            memReqValid && memReqWen && !memResValid |=> $stable(memReqData);
    endproperty

    // victim out then the refill read
    property writeBackThenAllocate;
        @(posedge isAllocateFinish) disable iff (clk)
            memReqValid && memReqWen && memResValid |=> memReqValid && !memReqWen;
    endproperty

    // memory port quiet while reset is held
    property quietInReset;
        @(posedge isAllocateFinish) clk |-> !memReqValid && !memReqWen;
    endproperty

    holdReq: assert property (reqHeldUntilResponse)
        else $error("memory request changed before memResValid");
    holdData: assert property (writeDataHeld)
        else $error("write-back data changed before memResValid");
    wbOrder: assert property (writeBackThenAllocate)
        else $error("write-back not followed by an allocate read");
    resetQuiet: assert property (quietInReset)
        else $error("memory request active during reset");

endmodule

bind cacheTop cacheTopAssertions memPortChecks (
    .isAllocateFinish(isAllocateFinish),
    .clk             (clk),
    .memReqAddr      (memReqAddr),
    .memReqData      (memReqData),
    .memReqWen       (memReqWen),
    .memReqValid     (memReqValid),
    .memResValid     (memResValid)
);

//--- src/cacheTop.sv
module cacheTop #(
    parameter int lineCount = 128  // 128 x 4 bytes = 512 bytes
) (
    input  logic           isAllocateFinish,  // clock
    input  logic           clk,               // async reset, active high

    // pipeline side
    input  cachePkg::addrT reqAddr,
    input  cachePkg::wordT reqData,
    input  logic           reqWen,
    input  logic           reqValid,
    output cachePkg::wordT resData,
    output logic           resStall,

    // memory side
    output cachePkg::addrT memReqAddr,
    output cachePkg::wordT memReqData,
    output logic           memReqWen,
    output logic           memReqValid,
    input  cachePkg::wordT memResData,
    input  logic           memResValid
);

    // lookup results one way, fill the other
    storageCtrlIf #(
        .lineCount(lineCount)
    ) ctrlBus ();

    // tag/data/valid/dirty arrays
    cacheStorage #(
        .lineCount(lineCount)
    ) storage (
        .isAllocateFinish(isAllocateFinish),
        .clk             (clk),
        .reqAddr         (reqAddr),
        .reqData         (reqData),
        .reqWen          (reqWen),
        .reqValid        (reqValid),
        .resData         (resData),
        .ctrl            (ctrlBus.storage)
    );

    // miss sequencer, owns the memory port
    cacheControl control (
        .isAllocateFinish(isAllocateFinish),
        .clk             (clk),
        .reqAddr         (reqAddr),
        .reqValid        (reqValid),
        .resStall        (resStall),
        .memReqAddr      (memReqAddr),
        .memReqData      (memReqData),
        .memReqWen       (memReqWen),
        .memReqValid     (memReqValid),
        .memResData      (memResData),
        .memResValid     (memResValid),
        .ctrl            (ctrlBus.control)
    );

endmodule

//--- src/cacheControl.sv
module cacheControl (
    input  logic           isAllocateFinish,  // clock
    input  logic           clk,               // async reset, active high
    input  cachePkg::addrT reqAddr,
    input  logic           reqValid,
    output logic           resStall,
    output cachePkg::addrT memReqAddr,
    output cachePkg::wordT memReqData,
    output logic           memReqWen,
    output logic           memReqValid,
    input  cachePkg::wordT memResData,
    input  logic           memResValid,
    storageCtrlIf.control  ctrl
);
    import cachePkg::*;

    ctrlStateT state;
    ctrlStateT nextState;

    logic missStart;   // valid request misses while idle
    logic wbDone;      // write-back acknowledged
    logic allocDone;   // allocate data arrived
    logic loadWb;      // start write-back transfer
    logic loadAlloc;   // start allocate transfer
    addrT allocAddr;

    assign missStart = (state == stIdle) && reqValid && !ctrl.lookupHit;
    assign wbDone    = (state == stWriteBack) && memResValid;
    assign allocDone = (state == stAllocate) && memResValid;

    // dirty victim goes out first
    assign loadWb    = missStart && ctrl.lookupDirty;
    assign loadAlloc = (missStart && !ctrl.lookupDirty) || wbDone;

    // word aligned fetch address
    assign allocAddr = {reqAddr[addrWidth-1:offsetWidth], {offsetWidth{1'b0}}};

    // stall on a fresh miss, and for the whole miss sequence
    assign resStall = (reqValid && !ctrl.lookupHit) || (state != stIdle);

    // line write happens on the edge that ends the allocate
    assign ctrl.fillEn   = allocDone;
    assign ctrl.fillData = memResData;

    always_comb begin
        nextState = state;
        case (state)
            stIdle: begin
                if (loadWb) begin
                    nextState = stWriteBack;
                end else if (loadAlloc) begin
                    nextState = stAllocate;
                end
            end
            stWriteBack: begin
                if (wbDone) begin
                    nextState = stAllocate;  // refill right after the victim is out
                end
            end
            stAllocate: begin
                if (allocDone) begin
                    nextState = stIdle;
                end
            end
            default: nextState = stIdle;
        endcase
    end

    // state and memory handshake
    always_ff @(posedge isAllocateFinish or posedge clk) begin
        if (clk) begin
            state       <= stIdle;
            memReqValid <= 1'b0;
            memReqWen   <= 1'b0;
        end else begin
            state <= nextState;
            if (loadWb) begin
                memReqValid <= 1'b1;
                memReqWen   <= 1'b1;
            end else if (loadAlloc) begin
                memReqValid <= 1'b1;  // stays high straight from write-back into allocate
                memReqWen   <= 1'b0;
            end else if (allocDone) begin
                memReqValid <= 1'b0;
            end
            // otherwise hold while memory is busy
        end
    end

    // memory payload, loaded once per transfer and held
    always_ff @(posedge isAllocateFinish) begin
        if (loadWb) begin
            memReqAddr <= ctrl.victimAddr;
            memReqData <= ctrl.victimData;
        end else if (loadAlloc) begin
            memReqAddr <= allocAddr;  // data is ignored on reads
        end
    end

endmodule

//--- src/cacheStorage.sv
module cacheStorage #(
    parameter int lineCount = 128
) (
    input  logic           isAllocateFinish,  // clock
    input  logic           clk,               // async reset, active high
    input  cachePkg::addrT reqAddr,
    input  cachePkg::wordT reqData,
    input  logic           reqWen,
    input  logic           reqValid,
    output cachePkg::wordT resData,
    storageCtrlIf.storage  ctrl
);
    import cachePkg::*;

    localparam int indexWidth = $clog2(lineCount);
    localparam int tagWidth   = addrWidth - indexWidth - offsetWidth;

    typedef logic [indexWidth-1:0] indexT;
    typedef logic [tagWidth-1:0]   tagT;

    // per line fields
    tagT              tagArr  [lineCount];
    wordT             dataArr [lineCount];
    logic [lineCount-1:0] validBits;  // cleared by reset
    logic [lineCount-1:0] dirtyBits;  // cleared by reset

    indexT reqIndex;
    tagT   reqTag;
    tagT   storedTag;
    logic  storedValid;
    logic  writeHit;

    // split the byte address
    assign reqIndex = reqAddr[offsetWidth +: indexWidth];
    assign reqTag   = reqAddr[addrWidth-1 -: tagWidth];

    // selected line
    assign storedTag   = tagArr[reqIndex];
    assign storedValid = validBits[reqIndex];

    assign ctrl.lookupHit   = storedValid && (storedTag == reqTag);
    assign ctrl.lookupDirty = storedValid && dirtyBits[reqIndex];  // only valid lines need writing back

    // victim for write-back, rebuilt from stored tag and current index
    assign ctrl.victimAddr = {storedTag, reqIndex, {offsetWidth{1'b0}}};
    assign ctrl.victimData = dataArr[reqIndex];

    // read path, same cycle
    // only meaningful while lookupHit is high
    assign resData = dataArr[reqIndex];

    // hit means the sequencer is idle, so no extra state check needed
    assign writeHit = reqValid && reqWen && ctrl.lookupHit;

    // tag and data arrays
    always_ff @(posedge isAllocateFinish) begin
        if (ctrl.fillEn) begin
            tagArr[reqIndex] <= reqTag;
            // write miss merges the request word over the fetched one
            if (reqWen) begin
                dataArr[reqIndex] <= reqData;
            end else begin
                dataArr[reqIndex] <= ctrl.fillData;
            end
        end else if (writeHit) begin
            dataArr[reqIndex] <= reqData;  // write hit
        end
    end

    // valid and dirty flags
    always_ff @(posedge isAllocateFinish or posedge clk) begin
        if (clk) begin
            validBits <= '0;  // every line invalid after reset
            dirtyBits <= '0;
        end else if (ctrl.fillEn) begin
            validBits[reqIndex] <= 1'b1;
            dirtyBits[reqIndex] <= reqWen;  // allocate on write leaves line dirty
        end else if (writeHit) begin
            dirtyBits[reqIndex] <= 1'b1;
        end
    end

endmodule

//--- src/storageCtrlIf.sv
interface storageCtrlIf #(
    parameter int lineCount = 128
);
    import cachePkg::*;

    // index width comes from lineCount, so it has to be a power of two
    if (lineCount < 2 || (lineCount & (lineCount - 1)) != 0) begin : gLineCountCheck
        $error("storageCtrlIf: lineCount must be a power of two, at least 2");
    end

    logic lookupHit;    // tag match and valid on current request
    logic lookupDirty;  // selected line is valid and dirty
    addrT victimAddr;   // stored tag + index, offset zero
    wordT victimData;   // stored word of selected line
    logic fillEn;       // allocate finished, write line this edge
    wordT fillData;     // word returned by memory

    // array side
    modport storage (
        output lookupHit, lookupDirty, victimAddr, victimData,
        input  fillEn, fillData
    );

    // sequencer side
    modport control (
        input  lookupHit, lookupDirty, victimAddr, victimData,
        output fillEn, fillData
    );

endinterface

//--- src/cachePkg.sv
package cachePkg;

    // fixed geometry, independent of line count
    parameter int addrWidth   = 32;  // byte address
    parameter int dataWidth   = 32;  // one word per line
    parameter int offsetWidth = 2;   // byte offset inside a word

    // byte address as seen by pipeline and memory
    typedef logic [addrWidth-1:0] addrT;

    // data word, also the whole cache line
    typedef logic [dataWidth-1:0] wordT;

    // miss sequencer
    // stIdle      -> hits served, misses detected here
    // stWriteBack -> dirty victim going out to memory
    // stAllocate  -> missed word coming in from memory
    typedef enum logic [1:0] {
        stIdle      = 2'd0,
        stWriteBack = 2'd1,
        stAllocate  = 2'd2
    } ctrlStateT;

endpackage
